// File: lsu_top.f
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_load_unit.sv
hw/lsu_store_unit.sv
hw/lsu_commit.sv
hw/lsu_top.sv
bench/lsu_properties.sv
bench/lsu_tb.sv

// File: bench/lsu_tb.sv
`timescale 1ns/1ns

module lsu_tb import lsu_pkg::*; ();

  localparam int unsigned RSP_TIMEOUT    = 32;
  localparam int unsigned NUM_RANDOM_OPS = 200;

  logic        clk;
  logic        reset;
  lsu_req_t    req_i;
  logic        ifu_stall_i;
  rd_bus_rsp_t rd_bus_rsp_i;
  wr_bus_rsp_t wr_bus_rsp_i;
  rd_bus_req_t rd_bus_req_o;
  wr_bus_req_t wr_bus_req_o;
  logic        mem_stall_o;
  logic        rd_wen_o;
  data_t       result_o;
  logic [31:0] lfsr;

  lsu_top i_dut (.*);

  always #4 clk = ~clk;

  // ##########################################################################
  // Random source, model and checks
  // ##########################################################################

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1.
  endfunction

  task automatic rand_bits(input int unsigned n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  function automatic bus_size_t model_size(input lsu_op_t op, input funct3_t f3);
    if (op == LSU_OP_LOAD && (f3 == 3'd4 || f3 == 3'd5)) return bus_size_t'(f3 - 3'd4);
    if (f3 <= 3'd2) return bus_size_t'(f3);
    return bus_size_t'(0);
  endfunction

  function automatic data_t model_load(input funct3_t f3, input data_t raw);
    logic signed [7:0]  b;
    logic signed [15:0] h;
    int                 v;
    b = raw[7:0];
    h = raw[15:0];
    case (f3)
      3'd0: begin
        v = b;
        return data_t'(v);
      end
      3'd1: begin
        v = h;
        return data_t'(v);
      end
      3'd2: return raw;
      3'd4: return raw & 32'h0000_00ff;
      3'd5: return raw & 32'h0000_ffff;
      default: return '0;
    endcase
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_request(input lsu_op_t op, input funct3_t f3, input data_t src1,
                               input data_t src2, input data_t imm);
    addr_t exp_addr;
    exp_addr = src1 + imm;
    check_value("rd_bus_req_o.valid", rd_bus_req_o.valid, op == LSU_OP_LOAD);
    check_value("wr_bus_req_o.valid", wr_bus_req_o.valid, op == LSU_OP_STORE);
    if (op == LSU_OP_LOAD) begin
      check_value("rd_bus_req_o.addr", rd_bus_req_o.addr, exp_addr);
      check_value("rd_bus_req_o.size", rd_bus_req_o.size, model_size(op, f3));
    end else begin
      check_value("wr_bus_req_o.addr", wr_bus_req_o.addr, exp_addr);
      check_value("wr_bus_req_o.data", wr_bus_req_o.data, src2);   // Unshifted src2.
      check_value("wr_bus_req_o.size", wr_bus_req_o.size, model_size(op, f3));
    end
  endtask

  task automatic check_idle();
    check_value("rd_bus_req_o.valid", rd_bus_req_o.valid, 0);
    check_value("wr_bus_req_o.valid", wr_bus_req_o.valid, 0);
    check_value("mem_stall_o", mem_stall_o, 0);
  endtask

  task automatic draw_operands(output data_t src1, output data_t src2, output data_t imm,
                               output int unsigned delay);
    logic [31:0] bits;
    rand_bits(32, src1);
    rand_bits(32, src2);
    rand_bits(12, bits);
    imm = {{20{bits[11]}}, bits[11:0]};   // Sign-extended I/S immediate.
    rand_bits(3, bits);
    delay = bits;
  endtask

  // ##########################################################################
  // One operation with the bus slave
  // ##########################################################################

  task automatic run_op(input lsu_op_t op, input funct3_t f3, input data_t src1,
                        input data_t src2, input data_t imm, input logic stall,
                        input int unsigned delay);
    data_t       rdata;
    data_t       junk;
    data_t       exp_result;
    logic [31:0] bits;
    int unsigned cycles;
    rand_bits(32, rdata);
    exp_result    = (op == LSU_OP_LOAD) ? model_load(f3, rdata) : '0;
    req_i.op      = op;
    req_i.funct3  = f3;
    req_i.src1    = src1;
    req_i.src2    = src2;
    req_i.imm     = imm;
    ifu_stall_i   = stall;
    @(negedge clk);
    req_i.op    = LSU_OP_NONE;
    ifu_stall_i = 1'b0;
    if (stall) begin
      for (int i = 0; i < 6; i++) begin
        check_idle();
        check_value("rd_wen_o", rd_wen_o, 0);
        @(negedge clk);
      end
    end else begin
      cycles = 0;
      while (!rd_wen_o) begin
        if (cycles > RSP_TIMEOUT) stop_on_error("Timed out waiting for rd_wen_o.");
        check_request(op, f3, src1, src2, imm);
        check_value("mem_stall_o", mem_stall_o, 1);
        rand_bits(32, junk);
        rand_bits(2, bits);
        if (cycles >= delay) begin
          rd_bus_rsp_i = {1'b1, rdata, 1'b1};
          wr_bus_rsp_i = 2'b11;
        end else begin
          rd_bus_rsp_i = {bits[1], junk, bits[0] & ~bits[1]};   // Never ready with last.
          wr_bus_rsp_i = {bits[1], bits[0] & ~bits[1]};
        end
        if (op == LSU_OP_LOAD) wr_bus_rsp_i = '0;
        else rd_bus_rsp_i = '0;
        @(negedge clk);
        cycles++;
      end
      check_value("rd_wen_o latency", cycles, delay + 1);
      rd_bus_rsp_i = '0;
      wr_bus_rsp_i = '0;
      check_value("result_o", result_o, exp_result);
      check_idle();
      @(negedge clk);
      check_value("rd_wen_o", rd_wen_o, 0);
    end
  endtask

  always @(negedge clk) begin
    if (i_dut.i_lsu_properties.failures != 0) begin
      stop_on_error("A bus or writeback assertion failed.");
    end
  end

  initial begin
    logic [31:0] bits;
    lsu_op_t     op;
    funct3_t     f3;
    logic        stall;
    data_t       src1;
    data_t       src2;
    data_t       imm;
    int unsigned delay;
    clk          = 1'b0;
    reset        = 1'b1;
    req_i        = '0;
    ifu_stall_i  = 1'b0;
    rd_bus_rsp_i = '0;
    wr_bus_rsp_i = '0;
    lfsr         = 32'h5c6e_9d96;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    check_idle();
    check_value("rd_wen_o", rd_wen_o, 0);

    for (int k = 0; k < 8; k++) begin   // Every load funct3 including the undefined ones.
      draw_operands(src1, src2, imm, delay);
      run_op(LSU_OP_LOAD, funct3_t'(k), src1, src2, imm, 1'b0, delay);
    end
    for (int k = 0; k < 3; k++) begin
      draw_operands(src1, src2, imm, delay);
      run_op(LSU_OP_STORE, funct3_t'(k), src1, src2, imm, 1'b0, delay);
    end
    draw_operands(src1, src2, imm, delay);
    run_op(LSU_OP_LOAD, 3'd2, src1, src2, imm, 1'b1, delay);

    for (int n = 0; n < NUM_RANDOM_OPS; n++) begin
      rand_bits(1, bits);
      op = bits[0] ? LSU_OP_STORE : LSU_OP_LOAD;
      rand_bits(3, bits);
      f3 = bits[2:0];
      rand_bits(3, bits);
      stall = (bits[2:0] == 3'd0);
      draw_operands(src1, src2, imm, delay);
      run_op(op, f3, src1, src2, imm, stall, delay);
    end

    if (i_dut.i_lsu_properties.failures == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      stop_on_error("Assertion failures were recorded during the run.");
    end
  end

endmodule

// File: bench/lsu_properties.sv
`timescale 1ns/1ns

module lsu_properties import lsu_pkg::*; (
  input logic        clk,
  input logic        reset,
  input rd_bus_req_t rd_bus_req_i,
  input rd_bus_rsp_t rd_bus_rsp_i,
  input wr_bus_req_t wr_bus_req_i,
  input wr_bus_rsp_t wr_bus_rsp_i,
  input logic        rd_wen_i
);

  int unsigned failures = 0;   // Count of failed assertions.

  // ##########################################################################
  // Bus request and writeback rules
  // ##########################################################################

  a_rd_hold: assert property (@(posedge clk) disable iff (reset)
    rd_bus_req_i.valid && !(rd_bus_rsp_i.ready && rd_bus_rsp_i.last) |=>
      rd_bus_req_i.valid && $stable(rd_bus_req_i.addr) && $stable(rd_bus_req_i.size))
    else begin
      $error("read request dropped or changed before completion");
      failures++;
    end

  a_wr_hold: assert property (@(posedge clk) disable iff (reset)
    wr_bus_req_i.valid && !(wr_bus_rsp_i.ready && wr_bus_rsp_i.last) |=>
      wr_bus_req_i.valid && $stable(wr_bus_req_i.addr) && $stable(wr_bus_req_i.data) &&
      $stable(wr_bus_req_i.size))
    else begin
      $error("write request dropped or changed before completion");
      failures++;
    end

  a_wen_pulse: assert property (@(posedge clk) disable iff (reset) rd_wen_i |=> !rd_wen_i)
    else begin
      $error("register write enable held for two cycles");
      failures++;
    end

  a_one_channel: assert property (@(posedge clk) disable iff (reset)
    !(rd_bus_req_i.valid && wr_bus_req_i.valid))
    else begin
      $error("read and write requests active together");
      failures++;
    end

endmodule

bind lsu_top lsu_properties i_lsu_properties (
  .clk          (clk),
  .reset        (reset),
  .rd_bus_req_i (rd_bus_req_o),
  .rd_bus_rsp_i (rd_bus_rsp_i),
  .wr_bus_req_i (wr_bus_req_o),
  .wr_bus_rsp_i (wr_bus_rsp_i),
  .rd_wen_i     (rd_wen_o)
);

// File: hw/lsu_top.sv
`timescale 1ns/1ns

module lsu_top import lsu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  lsu_req_t    req_i,
  input  logic        ifu_stall_i,
  input  rd_bus_rsp_t rd_bus_rsp_i,
  input  wr_bus_rsp_t wr_bus_rsp_i,
  output rd_bus_req_t rd_bus_req_o,
  output wr_bus_req_t wr_bus_req_o,
  output logic        mem_stall_o,
  output logic        rd_wen_o,
  output data_t       result_o
);

  unit_done_t load_done;
  unit_done_t store_done;
  logic       load_busy;
  logic       store_busy;

  // ##########################################################################
  // Load and store units side by side
  // ##########################################################################

  lsu_load_unit i_load_unit (
    .clk          (clk),
    .reset        (reset),
    .req_i        (req_i),
    .ifu_stall_i  (ifu_stall_i),
    .rd_bus_rsp_i (rd_bus_rsp_i),
    .rd_bus_req_o (rd_bus_req_o),
    .done_o       (load_done),
    .busy_o       (load_busy)
  );

  lsu_store_unit i_store_unit (
    .clk          (clk),
    .reset        (reset),
    .req_i        (req_i),
    .ifu_stall_i  (ifu_stall_i),
    .wr_bus_rsp_i (wr_bus_rsp_i),
    .wr_bus_req_o (wr_bus_req_o),
    .done_o       (store_done),
    .busy_o       (store_busy)
  );

  // ##########################################################################
  // Commit to writeback
  // ##########################################################################

  lsu_commit i_commit (
    .clk          (clk),
    .reset        (reset),
    .load_done_i  (load_done),
    .store_done_i (store_done),
    .load_busy_i  (load_busy),
    .store_busy_i (store_busy),
    .rd_wen_o     (rd_wen_o),
    .result_o     (result_o),
    .mem_stall_o  (mem_stall_o)
  );

endmodule

// File: hw/lsu_commit.sv
`timescale 1ns/1ns

module lsu_commit import lsu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  unit_done_t load_done_i,
  input  unit_done_t store_done_i,
  input  logic       load_busy_i,
  input  logic       store_busy_i,
  output logic       rd_wen_o,
  output data_t      result_o,
  output logic       mem_stall_o
);

  logic  rd_wen_q;
  data_t result_q;
  logic  any_done;
  data_t done_data;

  // ##########################################################################
  // Writeback merge
  // ##########################################################################

  // Only one unit can be busy at a time, so at most one strobe is set.
  assign any_done  = load_done_i.done | store_done_i.done;
  assign done_data = load_done_i.done ? load_done_i.data : store_done_i.data;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_wen_q <= 1'b0;
    end else begin
      rd_wen_q <= any_done;   // The unit is idle after completion, so this pulses once.
    end
  end

  always_ff @(posedge clk) begin
    if (any_done) begin
      result_q <= done_data;
    end
  end

  assign rd_wen_o = rd_wen_q;
  assign result_o = result_q;

  // Stall covers the whole bus wait including the completion cycle itself.
  assign mem_stall_o = (load_busy_i | store_busy_i) & ~rd_wen_q;

endmodule

// File: hw/lsu_store_unit.sv
`timescale 1ns/1ns

module lsu_store_unit import lsu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  lsu_req_t    req_i,
  input  logic        ifu_stall_i,
  input  wr_bus_rsp_t wr_bus_rsp_i,
  output wr_bus_req_t wr_bus_req_o,
  output unit_done_t  done_o,
  output logic        busy_o
);

  unit_state_e state_q;
  unit_state_e state_d;
  addr_t       addr_q;
  data_t       data_q;
  bus_size_t   size_q;
  bus_size_t   size_d;
  logic        issue;
  logic        complete;

  assign issue    = (state_q == UNIT_IDLE) && (req_i.op == LSU_OP_STORE) && !ifu_stall_i;
  assign complete = (state_q == UNIT_WAIT) && wr_bus_rsp_i.ready && wr_bus_rsp_i.last;

  // ##########################################################################
  // Request state machine
  // ##########################################################################

  always_comb begin
    state_d = state_q;
    case (state_q)
      UNIT_IDLE: begin
        if (issue) begin
          state_d = UNIT_WAIT;
        end
      end
      UNIT_WAIT: begin
        if (complete) begin
          state_d = UNIT_IDLE;
        end
      end
      default: begin
        state_d = UNIT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= UNIT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    case (req_i.funct3)
      3'b000:  size_d = bus_size_t'(0);
      3'b001:  size_d = bus_size_t'(1);
      3'b010:  size_d = bus_size_t'(2);
      default: size_d = bus_size_t'(0);
    endcase
  end

  // The data goes out unshifted and the slave places it by address and size.
  always_ff @(posedge clk) begin
    if (issue) begin
      addr_q <= addr_t'(req_i.src1 + req_i.imm);
      data_q <= req_i.src2;
      size_q <= size_d;
    end
  end

  assign wr_bus_req_o.valid = (state_q == UNIT_WAIT);
  assign wr_bus_req_o.addr  = addr_q;
  assign wr_bus_req_o.data  = data_q;
  assign wr_bus_req_o.size  = size_q;

  assign done_o.done = complete;
  assign done_o.data = '0;   // Stores write nothing back.

  assign busy_o = (state_q == UNIT_WAIT);

endmodule

// File: hw/lsu_load_unit.sv
`timescale 1ns/1ns

`include "lsu_params.svh"

module lsu_load_unit import lsu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  lsu_req_t    req_i,
  input  logic        ifu_stall_i,
  input  rd_bus_rsp_t rd_bus_rsp_i,
  output rd_bus_req_t rd_bus_req_o,
  output unit_done_t  done_o,
  output logic        busy_o
);

  unit_state_e state_q;
  unit_state_e state_d;
  addr_t       addr_q;
  funct3_t     funct3_q;
  bus_size_t   size;
  data_t       load_data;
  logic        issue;
  logic        complete;

  // ##########################################################################
  // Request state machine
  // ##########################################################################

  assign issue    = (state_q == UNIT_IDLE) && (req_i.op == LSU_OP_LOAD) && !ifu_stall_i;
  assign complete = (state_q == UNIT_WAIT) && rd_bus_rsp_i.ready && rd_bus_rsp_i.last;

  always_comb begin
    state_d = state_q;
    case (state_q)
      UNIT_IDLE: begin
        if (issue) begin
          state_d = UNIT_WAIT;
        end
      end
      UNIT_WAIT: begin
        if (complete) begin
          state_d = UNIT_IDLE;   // Single beat, so the first ready with last ends it.
        end
      end
      default: begin
        state_d = UNIT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= UNIT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      addr_q   <= addr_t'(req_i.src1 + req_i.imm);
      funct3_q <= req_i.funct3;
    end
  end

  // ##########################################################################
  // Size code and load data extension
  // ##########################################################################

  always_comb begin
    case (funct3_q)
      3'b000:  size = bus_size_t'(0);
      3'b001:  size = bus_size_t'(1);
      3'b010:  size = bus_size_t'(2);
      3'b100:  size = bus_size_t'(0);
      3'b101:  size = bus_size_t'(1);
      default: size = bus_size_t'(0);   // Undefined codes still issue as a byte read.
    endcase
  end

  always_comb begin
    case (funct3_q)
      3'b000:  load_data = {{(`LSU_DATA_WIDTH-8){rd_bus_rsp_i.data[7]}}, rd_bus_rsp_i.data[7:0]};
      3'b001:  load_data = {{(`LSU_DATA_WIDTH-16){rd_bus_rsp_i.data[15]}},
                            rd_bus_rsp_i.data[15:0]};
      3'b010:  load_data = rd_bus_rsp_i.data;
      3'b100:  load_data = {{(`LSU_DATA_WIDTH-8){1'b0}}, rd_bus_rsp_i.data[7:0]};
      3'b101:  load_data = {{(`LSU_DATA_WIDTH-16){1'b0}}, rd_bus_rsp_i.data[15:0]};
      default: load_data = '0;
    endcase
  end

  assign rd_bus_req_o.valid = (state_q == UNIT_WAIT);
  assign rd_bus_req_o.addr  = addr_q;
  assign rd_bus_req_o.size  = size;

  assign done_o.done = complete;
  assign done_o.data = load_data;

  assign busy_o = (state_q == UNIT_WAIT);

endmodule

// File: hw/lsu_pkg.sv
`include "lsu_params.svh"

package lsu_pkg;

  typedef logic [`LSU_DATA_WIDTH-1:0]   data_t;
  typedef logic [`LSU_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`LSU_SIZE_WIDTH-1:0]   bus_size_t;   // 0 byte, 1 halfword, 2 word.
  typedef logic [`LSU_FUNCT3_WIDTH-1:0] funct3_t;
  typedef logic [1:0]                   lsu_op_t;

  localparam lsu_op_t LSU_OP_NONE  = 2'd0;
  localparam lsu_op_t LSU_OP_LOAD  = 2'd1;
  localparam lsu_op_t LSU_OP_STORE = 2'd2;

  typedef enum logic {
    UNIT_IDLE,
    UNIT_WAIT
  } unit_state_e;

  // ##########################################################################
  // Execute stage request and bus channels
  // ##########################################################################

  typedef struct packed {
    lsu_op_t op;
    funct3_t funct3;
    data_t   src1;
    data_t   src2;
    data_t   imm;
  } lsu_req_t;

  typedef struct packed {
    logic      valid;
    addr_t     addr;
    bus_size_t size;
  } rd_bus_req_t;

  typedef struct packed {
    logic  ready;
    data_t data;
    logic  last;
  } rd_bus_rsp_t;

  typedef struct packed {
    logic      valid;
    addr_t     addr;
    data_t     data;
    bus_size_t size;
  } wr_bus_req_t;

  typedef struct packed {
    logic ready;
    logic last;
  } wr_bus_rsp_t;

  typedef struct packed {
    logic  done;
    data_t data;   // Holds the extended load value or zero for a store.
  } unit_done_t;

endpackage

// File: hw/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// ##########################################################################
// Widths of the load/store unit
// ##########################################################################

// Register file and bus data width.
`define LSU_DATA_WIDTH 32

// Bus address width.
`define LSU_ADDR_WIDTH 32

// The bus size code holds the log2 of the number of bytes in one transfer.
`define LSU_SIZE_WIDTH 3

// Width of the funct3 field of a load or store instruction.
`define LSU_FUNCT3_WIDTH 3

`endif
